// ==== logic/fpsu_pkg.sv ====
/*
  Shared types for the packed-single slice. Two IEEE singles per 64-bit word,
  with the low single in bits 31..0. Bus words carry even parity over all 65 bits.
*/
`default_nettype none

package fpsu_pkg;

  typedef logic [31:0] sngl_t;
  typedef logic [63:0] simd_t;

  // 0 issued, 1..N bus now, N+1..2N bus one edge back
  typedef logic [3:0] src_sel_t;

  typedef struct packed {
    logic  par;
    simd_t data;
  } bus_word_t;

  typedef enum logic [3:0] {
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ANDN,
    OP_SWAP,
    OP_DUPLO,
    OP_DUPHI,
    OP_CMPEQ,
    OP_CMPLT,
    OP_CMPLE
  } op_t;

  typedef struct packed {
    logic      valid;
    op_t       op;
    logic      ord;
    src_sel_t  a_sel;
    src_sel_t  b_sel;
    bus_word_t a;
    bus_word_t b;
  } issue_t;

  typedef struct packed {
    logic  valid;
    op_t   op;
    logic  ord;
    simd_t a;
    simd_t b;
    logic  parity_err;
  } oper_t;

  typedef struct packed {
    logic  valid;
    simd_t data;
  } lane_res_t;

  typedef struct packed {
    logic lt;
    logic eq;
    logic gt;
    logic un;
  } cmp_flags_t;

  typedef struct packed {
    logic      valid;
    bus_word_t word;
  } wb_t;

  typedef struct packed {
    logic       valid;
    logic       excpt;
    logic       parity_err;
    logic       invalid;
    cmp_flags_t flags;
  } ret_t;

  // parity bit that makes {par, d} even
  function automatic logic even_parity(simd_t d);
    return ^d;
  endfunction

endpackage

`default_nettype wire

// ==== logic/operand_stage.sv ====
/*
  Issue register and operand forwarding. "Now" codes read the live result bus
  in the resolve cycle, "old" codes the copy taken at the issue edge.
  src_sel_t is 4 bits, so NUM_FWD must not exceed 7.
*/
`timescale 1ns/1ps
`default_nettype none

module operand_stage
  import fpsu_pkg::*;
#(
  parameter int NUM_FWD = 4
) (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire issue_t    issue,
  input  wire bus_word_t fwd_bus [NUM_FWD],
  output oper_t          oper
);

  issue_t    issue_q;
  bus_word_t fwd_q [NUM_FWD];
  bus_word_t a_word;
  bus_word_t b_word;

  // operand source lookup
  function automatic bus_word_t pick(src_sel_t sel, bus_word_t issued);
    bus_word_t w;
    w = issued;
    for (int k = 0; k < NUM_FWD; k++) begin
      if (int'(sel) == k + 1) begin
        w = fwd_bus[k];
      end
      if (int'(sel) == NUM_FWD + k + 1) begin
        w = fwd_q[k];
      end
    end
    return w;
  endfunction

  always_ff @(posedge clk) begin
    issue_q <= issue;
    fwd_q   <= fwd_bus;
    if (rst) begin
      issue_q.valid <= 1'b0;
    end
  end

  always_comb begin
    a_word = pick(issue_q.a_sel, issue_q.a);
    b_word = pick(issue_q.b_sel, issue_q.b);
  end

  always_ff @(posedge clk) begin
    oper.op         <= issue_q.op;
    oper.ord        <= issue_q.ord;
    oper.a          <= a_word.data;
    oper.b          <= b_word.data;
    oper.parity_err <= (^a_word) | (^b_word);
    if (rst) begin
      oper.valid <= 1'b0;
    end else begin
      oper.valid <= issue_q.valid;
    end
  end

  // codes past the old-bus range have no source
  a_src_range: assert property (@(posedge clk) disable iff (rst)
    issue.valid |-> (int'(issue.a_sel) <= 2 * NUM_FWD) && (int'(issue.b_sel) <= 2 * NUM_FWD));

endmodule

`default_nettype wire

// ==== logic/perm_lane.sv ====
/*
  Bitwise logic and single permute lane, one cycle.
  Valid only for the logic and permute ops; other ops leave it idle.
*/
`timescale 1ns/1ps
`default_nettype none

module perm_lane
  import fpsu_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire oper_t oper,
  output lane_res_t  res
);

  logic  is_perm;
  simd_t data_nxt;

  assign is_perm = oper.op inside {OP_AND, OP_OR, OP_XOR, OP_ANDN,
                                   OP_SWAP, OP_DUPLO, OP_DUPHI};

  always_comb begin
    case (oper.op)
      OP_AND:   data_nxt = oper.a & oper.b;
      OP_OR:    data_nxt = oper.a | oper.b;
      OP_XOR:   data_nxt = oper.a ^ oper.b;
      OP_ANDN:  data_nxt = oper.a & ~oper.b;
      // singles of A only
      OP_SWAP:  data_nxt = {oper.a[31:0], oper.a[63:32]};
      OP_DUPLO: data_nxt = {oper.a[31:0], oper.a[31:0]};
      OP_DUPHI: data_nxt = {oper.a[63:32], oper.a[63:32]};
      default:  data_nxt = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    res.data <= data_nxt;
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= oper.valid & is_perm;
    end
  end

endmodule

`default_nettype wire

// ==== logic/cmp_lane.sv ====
/*
  Packed single compare. Each half gives all ones when the relation holds.
  Any NaN compares false; +0 and -0 are equal. Flags come from the low singles.
*/
`timescale 1ns/1ps
`default_nettype none

module cmp_lane
  import fpsu_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire oper_t oper,
  output lane_res_t  res,
  output cmp_flags_t flags,
  output logic       invalid
);

  function automatic logic is_nan(sngl_t s);
    return (s[30:23] == 8'hff) && (s[22:0] != '0);
  endfunction

  function automatic logic is_snan(sngl_t s);
    return is_nan(s) && !s[22];
  endfunction

  // exactly one flag set
  function automatic cmp_flags_t rel(sngl_t a, sngl_t b);
    cmp_flags_t f;
    logic       a_less;
    f = '0;
    if (is_nan(a) || is_nan(b)) begin
      f.un = 1'b1;
    end else if ((a[30:0] == '0 && b[30:0] == '0) || a == b) begin
      f.eq = 1'b1;
    end else begin
      if (a[31] != b[31]) begin
        a_less = a[31];
      end else begin
        a_less = a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]);
      end
      f.lt = a_less;
      f.gt = !a_less;
    end
    return f;
  endfunction

  function automatic logic holds(op_t op, cmp_flags_t f);
    return (op == OP_CMPEQ && f.eq) || (op == OP_CMPLT && f.lt) ||
           (op == OP_CMPLE && (f.lt || f.eq));
  endfunction

  cmp_flags_t f_lo;
  cmp_flags_t f_hi;
  logic       is_cmp;
  logic       any_nan;
  logic       any_snan;

  assign f_lo     = rel(oper.a[31:0], oper.b[31:0]);
  assign f_hi     = rel(oper.a[63:32], oper.b[63:32]);
  assign is_cmp   = oper.op inside {OP_CMPEQ, OP_CMPLT, OP_CMPLE};
  assign any_nan  = is_nan(oper.a[31:0]) || is_nan(oper.a[63:32]) ||
                    is_nan(oper.b[31:0]) || is_nan(oper.b[63:32]);
  assign any_snan = is_snan(oper.a[31:0]) || is_snan(oper.a[63:32]) ||
                    is_snan(oper.b[31:0]) || is_snan(oper.b[63:32]);

  always_ff @(posedge clk) begin
    res.data <= {{32{holds(oper.op, f_hi)}}, {32{holds(oper.op, f_lo)}}};
    if (rst) begin
      res.valid <= 1'b0;
      flags     <= '0;
      invalid   <= 1'b0;
    end else begin
      res.valid <= oper.valid & is_cmp;
      flags     <= is_cmp ? f_lo : '0;
      invalid   <= is_cmp & ((oper.ord & any_nan) | any_snan);
    end
  end

endmodule

`default_nettype wire

// ==== logic/wb_arbiter.sv ====
/*
  Write-back bus owner. Lane results always win and never wait.
  Alternate data is taken in a cycle with no lane result; alt_valid and
  alt_data must hold until alt_grant.
*/
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter
  import fpsu_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire lane_res_t perm_res,
  input  wire lane_res_t cmp_res,
  input  wire logic      alt_valid,
  input  wire simd_t     alt_data,
  output wb_t            wb,
  output logic           alt_grant
);

  logic  lane_v;
  logic  take_alt;
  simd_t data_nxt;

  assign lane_v = perm_res.valid | cmp_res.valid;

  // grant cycle still sees the held request
  assign take_alt = alt_valid & ~lane_v & ~alt_grant;

  always_comb begin
    if (perm_res.valid) begin
      data_nxt = perm_res.data;
    end else if (cmp_res.valid) begin
      data_nxt = cmp_res.data;
    end else begin
      data_nxt = alt_data;
    end
  end

  always_ff @(posedge clk) begin
    wb.word.data <= data_nxt;
    wb.word.par  <= even_parity(data_nxt);
    if (rst) begin
      wb.valid  <= 1'b0;
      alt_grant <= 1'b0;
    end else begin
      wb.valid  <= lane_v | take_alt;
      alt_grant <= take_alt;
    end
  end

  // one op per issue slot, so lanes cannot collide
  one_lane: assert property (@(posedge clk) disable iff (rst)
    !(perm_res.valid && cmp_res.valid));

endmodule

`default_nettype wire

// ==== logic/retire_unit.sv ====
/*
  Retire word, aligned with write-back. Issued only for lane results.
  Invalid raises excpt only while inv_trap_en is set.
*/
`timescale 1ns/1ps
`default_nettype none

module retire_unit
  import fpsu_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       oper_valid,
  input  wire logic       parity_err,
  input  wire logic       lane_valid,
  input  wire logic       invalid,
  input  wire cmp_flags_t flags,
  input  wire logic       inv_trap_en,
  output ret_t            ret
);

  logic perr_q;

  // parity error lines up with the lane outputs
  always_ff @(posedge clk) begin
    if (rst) begin
      perr_q <= 1'b0;
      ret    <= '0;
    end else begin
      perr_q         <= oper_valid & parity_err;
      ret.valid      <= lane_valid;
      ret.parity_err <= lane_valid & perr_q;
      ret.invalid    <= lane_valid & invalid;
      ret.excpt      <= lane_valid & (perr_q | (invalid & inv_trap_en));
      ret.flags      <= lane_valid ? flags : '0;
    end
  end

  ret_follows_oper: assert property (@(posedge clk) disable iff (rst)
    lane_valid |-> $past(oper_valid));

endmodule

`default_nettype wire

// ==== logic/fpsu_top.sv ====
/*
  Packed-single execution slice. Issue to write-back is 3 cycles, no stall.
  NUM_FWD result buses feed forwarding; at most 7 fit the source code.
*/
`timescale 1ns/1ps
`default_nettype none

module fpsu_top
  import fpsu_pkg::*;
#(
  parameter int NUM_FWD = 4
) (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire issue_t    issue,
  input  wire bus_word_t fwd_bus [NUM_FWD],
  input  wire logic      inv_trap_en,
  input  wire logic      alt_valid,
  input  wire simd_t     alt_data,
  output wb_t            wb,
  output ret_t           ret,
  output logic           alt_grant
);

  oper_t      oper;
  lane_res_t  perm_res;
  lane_res_t  cmp_res;
  cmp_flags_t cmp_flags;
  logic       cmp_invalid;

  operand_stage #(.NUM_FWD(NUM_FWD)) u_operand_stage (
    .clk(clk), .rst(rst), .issue(issue), .fwd_bus(fwd_bus), .oper(oper)
  );

  perm_lane u_perm_lane (
    .clk(clk), .rst(rst), .oper(oper), .res(perm_res)
  );

  cmp_lane u_cmp_lane (
    .clk(clk), .rst(rst), .oper(oper), .res(cmp_res),
    .flags(cmp_flags), .invalid(cmp_invalid)
  );

  wb_arbiter u_wb_arbiter (
    .clk(clk), .rst(rst), .perm_res(perm_res), .cmp_res(cmp_res),
    .alt_valid(alt_valid), .alt_data(alt_data), .wb(wb), .alt_grant(alt_grant)
  );

  retire_unit u_retire_unit (
    .clk(clk), .rst(rst), .oper_valid(oper.valid), .parity_err(oper.parity_err),
    .lane_valid(perm_res.valid | cmp_res.valid), .invalid(cmp_invalid),
    .flags(cmp_flags), .inv_trap_en(inv_trap_en), .ret(ret)
  );

endmodule

`default_nettype wire

// ==== test/tb_fpsu.sv ====
/*
  Directed testbench for the packed-single slice. Inputs change on the falling
  edge and outputs are sampled there. Expected values come from a local model.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_fpsu
  import fpsu_pkg::*;
();

  localparam int NUM_FWD = 4;
  localparam int TIMEOUT = 20;

  localparam sngl_t ONE     = 32'h3f800000;
  localparam sngl_t TWO     = 32'h40000000;
  localparam sngl_t NEG_1P5 = 32'hbfc00000;
  localparam sngl_t POS_Z   = 32'h00000000;
  localparam sngl_t NEG_Z   = 32'h80000000;
  localparam sngl_t QNAN    = 32'h7fc00000;
  localparam sngl_t SNAN    = 32'h7f800001;

  logic      clk;
  logic      rst;
  issue_t    issue;
  bus_word_t fwd_bus [NUM_FWD];
  logic      inv_trap_en;
  logic      alt_valid;
  simd_t     alt_data;
  wb_t       wb;
  ret_t      ret;
  logic      alt_grant;

  int        seed;
  int        check_cnt;
  int        err_cnt;
  int        test_chk_base;
  int        test_err_base;
  bus_word_t bus_at_issue [NUM_FWD];
  bus_word_t bus_next [NUM_FWD];

  fpsu_top #(.NUM_FWD(NUM_FWD)) UUT (
    .clk(clk), .rst(rst), .issue(issue), .fwd_bus(fwd_bus), .inv_trap_en(inv_trap_en),
    .alt_valid(alt_valid), .alt_data(alt_data), .wb(wb), .ret(ret), .alt_grant(alt_grant)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic nan_s(sngl_t s);
    return (&s[30:23]) && (|s[22:0]);
  endfunction

  // total order on non-NaN singles with both zeros at 0
  function automatic logic signed [32:0] order_key(sngl_t s);
    logic signed [32:0] mag;
    mag = $signed({2'b00, s[30:0]});
    return s[31] ? -mag : mag;
  endfunction

  function automatic cmp_flags_t model_rel(sngl_t a, sngl_t b);
    cmp_flags_t f;
    f = '0;
    if (nan_s(a) || nan_s(b)) begin
      f.un = 1'b1;
    end else if (order_key(a) < order_key(b)) begin
      f.lt = 1'b1;
    end else if (order_key(a) > order_key(b)) begin
      f.gt = 1'b1;
    end else begin
      f.eq = 1'b1;
    end
    return f;
  endfunction

  function automatic logic is_cmp_op(op_t op);
    return op inside {OP_CMPEQ, OP_CMPLT, OP_CMPLE};
  endfunction

  function automatic logic model_holds(op_t op, cmp_flags_t f);
    case (op)
      OP_CMPEQ: return f.eq;
      OP_CMPLT: return f.lt;
      default:  return f.lt | f.eq;
    endcase
  endfunction

  function automatic simd_t model_result(op_t op, simd_t a, simd_t b);
    sngl_t a_lo;
    sngl_t a_hi;
    a_lo = a[31:0];
    a_hi = a[63:32];
    case (op)
      OP_AND:   return a & b;
      OP_OR:    return a | b;
      OP_XOR:   return a ^ b;
      OP_ANDN:  return a & ~b;
      OP_SWAP:  return {a_lo, a_hi};
      OP_DUPLO: return {a_lo, a_lo};
      OP_DUPHI: return {a_hi, a_hi};
      default:  return {{32{model_holds(op, model_rel(a_hi, b[63:32]))}},
                        {32{model_holds(op, model_rel(a_lo, b[31:0]))}}};
    endcase
  endfunction

  function automatic logic model_invalid(logic ord, simd_t a, simd_t b);
    sngl_t v [4];
    logic  bad;
    v = '{a[31:0], a[63:32], b[31:0], b[63:32]};
    bad = 1'b0;
    for (int i = 0; i < 4; i++) begin
      // quiet bit clear means signaling
      if (nan_s(v[i]) && (ord || !v[i][22])) begin
        bad = 1'b1;
      end
    end
    return bad;
  endfunction

  function automatic ret_t model_ret(op_t op, logic ord, simd_t a, simd_t b,
                                     logic perr, logic trap);
    ret_t r;
    r = '0;
    r.valid = 1'b1;
    r.parity_err = perr;
    if (is_cmp_op(op)) begin
      r.invalid = model_invalid(ord, a, b);
      r.flags = model_rel(a[31:0], b[31:0]);
    end
    r.excpt = perr | (r.invalid & trap);
    return r;
  endfunction

  function automatic simd_t pick_src(src_sel_t sel, simd_t issued);
    if (sel == 4'd0) begin
      return issued;
    end else if (int'(sel) <= NUM_FWD) begin
      return bus_next[int'(sel) - 1].data;
    end
    return bus_at_issue[int'(sel) - NUM_FWD - 1].data;
  endfunction

  task automatic check_word(input simd_t got, input simd_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s data %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ret(input ret_t got, input ret_t exp, input string what);
    check_cnt++;
    if ({got.valid, got.excpt, got.parity_err, got.invalid} !==
        {exp.valid, exp.excpt, exp.parity_err, exp.invalid}) begin
      err_cnt++;
      $display("error at %0t: %s retire v/exc/perr/inv %b%b%b%b, expected %b%b%b%b",
               $time, what, got.valid, got.excpt, got.parity_err, got.invalid,
               exp.valid, exp.excpt, exp.parity_err, exp.invalid);
    end
  endtask

  task automatic check_flags(input cmp_flags_t got, input cmp_flags_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s flags lt/eq/gt/un %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    check_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("error at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $finish;
  endtask

  task automatic wait_wb(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (wb.valid !== 1'b1 && cycles < TIMEOUT);
    if (wb.valid !== 1'b1) begin
      abort_run($sformatf("timeout: no write-back within %0d cycles", TIMEOUT));
    end
  endtask

  task automatic begin_test();
    test_chk_base = check_cnt;
    test_err_base = err_cnt;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, check_cnt - test_chk_base,
             err_cnt - test_err_base);
  endtask

  task automatic drive_op(input op_t op, input logic ord, input src_sel_t a_sel,
                          input src_sel_t b_sel, input simd_t a, input simd_t b,
                          input logic [1:0] flip);
    @(negedge clk);
    issue.valid = 1'b1;
    issue.op = op;
    issue.ord = ord;
    issue.a_sel = a_sel;
    issue.b_sel = b_sel;
    issue.a.data = a;
    issue.a.par = (^a) ^ flip[0];
    issue.b.data = b;
    issue.b.par = (^b) ^ flip[1];
  endtask

  task automatic end_issue();
    @(negedge clk);
    issue.valid = 1'b0;
  endtask

  task automatic check_result(input op_t op, input logic ord, input simd_t a, input simd_t b,
                              input logic perr, input string what);
    ret_t exp_ret;
    exp_ret = model_ret(op, ord, a, b, perr, inv_trap_en);
    check_word(wb.word.data, model_result(op, a, b), what);
    check_bit(^wb.word, 1'b0, {what, " parity"});
    check_ret(ret, exp_ret, what);
    check_flags(ret.flags, exp_ret.flags, what);
  endtask

  task automatic run_one(input op_t op, input logic ord, input simd_t a, input simd_t b,
                         input logic [1:0] flip, input string what);
    int cycles;
    drive_op(op, ord, 4'd0, 4'd0, a, b, flip);
    end_issue();
    wait_wb(cycles);
    check_count(cycles, 3, {what, " latency"});
    check_result(op, ord, a, b, |flip, what);
  endtask

  task automatic test_logic_ops();
    simd_t a;
    simd_t b;
    op_t   op;
    begin_test();
    for (int i = 0; i <= int'(OP_DUPHI); i++) begin
      op = op_t'(i);
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      run_one(op, 1'b0, a, b, 2'b00, op.name());
    end
    end_test("logic ops");
  endtask

  task automatic cmp_case(input op_t op, input logic ord, input logic trap, input sngl_t a_lo,
                          input sngl_t b_lo, input sngl_t a_hi, input sngl_t b_hi,
                          input string what);
    inv_trap_en = trap;
    run_one(op, ord, {a_hi, a_lo}, {b_hi, b_lo}, 2'b00, what);
  endtask

  task automatic test_compare();
    begin_test();
    cmp_case(OP_CMPLT, 1'b0, 1'b0, ONE, TWO, TWO, ONE, "lt ordinary");
    cmp_case(OP_CMPEQ, 1'b0, 1'b0, POS_Z, NEG_Z, NEG_1P5, ONE, "eq zeros");
    cmp_case(OP_CMPLE, 1'b0, 1'b0, NEG_Z, POS_Z, NEG_1P5, NEG_1P5, "le zeros");
    cmp_case(OP_CMPLE, 1'b0, 1'b0, TWO, ONE, NEG_1P5, TWO, "le greater");
    cmp_case(OP_CMPEQ, 1'b0, 1'b1, QNAN, ONE, ONE, ONE, "qnan unordered");
    cmp_case(OP_CMPEQ, 1'b1, 1'b0, QNAN, ONE, ONE, ONE, "qnan ordered");
    // NaN only in the high half
    cmp_case(OP_CMPLT, 1'b1, 1'b1, ONE, ONE, QNAN, TWO, "qnan ordered trap");
    cmp_case(OP_CMPLE, 1'b0, 1'b0, TWO, SNAN, ONE, TWO, "snan");
    cmp_case(OP_CMPLE, 1'b0, 1'b1, TWO, SNAN, ONE, TWO, "snan trap");
    inv_trap_en = 1'b0;
    end_test("compare");
  endtask

  task automatic fwd_case(input op_t op, input src_sel_t a_sel, input src_sel_t b_sel,
                          input string what);
    simd_t ia;
    simd_t ib;
    simd_t exp_a;
    simd_t exp_b;
    int    cycles;
    ia = {$random(seed), $random(seed)};
    ib = {$random(seed), $random(seed)};
    for (int k = 0; k < NUM_FWD; k++) begin
      bus_at_issue[k].data = {$random(seed), $random(seed)};
      bus_at_issue[k].par = ^bus_at_issue[k].data;
      bus_next[k].data = {$random(seed), $random(seed)};
      bus_next[k].par = ^bus_next[k].data;
    end
    drive_op(op, 1'b0, a_sel, b_sel, ia, ib, 2'b00);
    fwd_bus = bus_at_issue;
    @(negedge clk);
    issue.valid = 1'b0;
    fwd_bus = bus_next;
    wait_wb(cycles);
    exp_a = pick_src(a_sel, ia);
    exp_b = pick_src(b_sel, ib);
    check_count(cycles, 3, {what, " latency"});
    check_result(op, 1'b0, exp_a, exp_b, 1'b0, what);
  endtask

  task automatic test_forwarding();
    begin_test();
    // old-bus codes start at NUM_FWD+1
    fwd_case(OP_XOR, 4'd1, src_sel_t'(NUM_FWD + 2), "bus0 now, bus1 old");
    fwd_case(OP_ANDN, src_sel_t'(NUM_FWD + 3), 4'd4, "bus2 old, bus3 now");
    fwd_case(OP_OR, 4'd0, src_sel_t'(NUM_FWD + 1), "issued, bus0 old");
    fwd_case(OP_SWAP, src_sel_t'(2 * NUM_FWD), 4'd2, "bus3 old, bus1 now");
    end_test("forwarding");
  endtask

  task automatic test_parity();
    simd_t a;
    simd_t b;
    begin_test();
    a = {$random(seed), $random(seed)};
    b = {$random(seed), $random(seed)};
    run_one(OP_AND, 1'b0, a, b, 2'b01, "a parity flipped");
    run_one(OP_CMPEQ, 1'b0, {ONE, TWO}, {ONE, ONE}, 2'b10, "b parity flipped");
    end_test("parity");
  endtask

  // three ops on consecutive slots and optional alternate data queued behind
  task automatic stream_three(input logic with_alt, input simd_t alt_word);
    op_t   ops [3];
    simd_t a [3];
    simd_t b [3];
    int    cycles;
    ops = '{OP_OR, OP_CMPLT, OP_DUPHI};
    for (int i = 0; i < 3; i++) begin
      a[i] = {$random(seed), $random(seed)};
      b[i] = {$random(seed), $random(seed)};
    end
    for (int i = 0; i < 3; i++) begin
      drive_op(ops[i], 1'b0, 4'd0, 4'd0, a[i], b[i], 2'b00);
    end
    end_issue();
    if (with_alt) begin
      alt_valid = 1'b1;
      alt_data = alt_word;
    end
    wait_wb(cycles);
    for (int i = 0; i < 3; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      check_bit(wb.valid, 1'b1, $sformatf("stream wb %0d valid", i));
      check_bit(alt_grant, 1'b0, $sformatf("stream slot %0d grant", i));
      check_result(ops[i], 1'b0, a[i], b[i], 1'b0, $sformatf("stream op %0d", i));
    end
    @(negedge clk);
    if (with_alt) begin
      check_bit(alt_grant, 1'b1, "alt grant after stream");
      check_bit(wb.valid, 1'b1, "alt wb valid");
      check_word(wb.word.data, alt_word, "alt after stream");
      check_bit(^wb.word, 1'b0, "alt parity");
      check_bit(ret.valid, 1'b0, "alt retire");
      alt_valid = 1'b0;
    end else begin
      check_bit(wb.valid, 1'b0, "wb after stream");
    end
  endtask

  task automatic test_back_to_back();
    begin_test();
    stream_three(1'b0, '0);
    end_test("back to back");
  endtask

  task automatic test_alt_data();
    simd_t word;
    int    cycles;
    begin_test();
    word = {$random(seed), $random(seed)};
    @(negedge clk);
    alt_valid = 1'b1;
    alt_data = word;
    wait_wb(cycles);
    check_bit(alt_grant, 1'b1, "idle alt grant");
    check_word(wb.word.data, word, "idle alt");
    check_bit(^wb.word, 1'b0, "idle alt parity");
    check_bit(ret.valid, 1'b0, "idle alt retire");
    alt_valid = 1'b0;
    @(negedge clk);
    check_bit(alt_grant, 1'b0, "grant after one cycle");
    check_bit(wb.valid, 1'b0, "wb after alt");
    stream_three(1'b1, {$random(seed), $random(seed)});
    end_test("alt data");
  endtask

  initial begin
    seed = 32'hbddf;
    check_cnt = 0;
    err_cnt = 0;
    rst = 1'b1;
    issue = '0;
    inv_trap_en = 1'b0;
    alt_valid = 1'b0;
    alt_data = '0;
    for (int k = 0; k < NUM_FWD; k++) begin
      fwd_bus[k] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_logic_ops();
    test_compare();
    test_forwarding();
    test_parity();
    test_back_to_back();
    test_alt_data();
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/fpsu_pkg.sv
logic/operand_stage.sv
logic/perm_lane.sv
logic/cmp_lane.sv
logic/wb_arbiter.sv
logic/retire_unit.sv
logic/fpsu_top.sv
test/tb_fpsu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile with Verilator and run the testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_fpsu -o sim_fpsu

out=$(./obj_dir/sim_fpsu)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
